//--- project.f
common/lsu_pkg.sv
verilog/lsu_store_align.sv
verilog/lsu_issue.sv
verilog/lsu_tag_fifo.sv
verilog/lsu_load_extract.sv
verilog/lsu_ret_buf.sv
verilog/lsu_top.sv
tests/lsu_props.sv
tests/lsu_tb.sv

//--- Bender.yml
package:
  name: lsu

sources:
  - common/lsu_pkg.sv
  - verilog/lsu_store_align.sv
  - verilog/lsu_issue.sv
  - verilog/lsu_tag_fifo.sv
  - verilog/lsu_load_extract.sv
  - verilog/lsu_ret_buf.sv
  - verilog/lsu_top.sv
  - target: simulation
    files:
      - tests/lsu_props.sv
      - tests/lsu_tb.sv

//--- tests/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;

    localparam int TAG_DEPTH = 2;

    typedef struct {
        string       name;
        int          src;    // 0 execute, 1 coprocessor, 2 both at once
        bit          read;
        logic [31:0] base;
        logic [31:0] imm;
        logic [31:0] data;
        logic [1:0]  size;
        bit          unsign;
        logic [4:0]  rdidx;
        bit          ret;
    } op_t;

    logic clk;
    logic rst_n_i;
    logic exu_vld_i;
    logic nice_vld_i;
    logic cmd_rdy_i;
    logic rsp_vld_i;
    logic wb_rdy_i;
    logic nice_ret_rdy_i;
    logic exu_rdy_o;
    logic nice_rdy_o;
    logic cmd_vld_o;
    logic rsp_rdy_o;
    logic wb_vld_o;
    logic nice_ret_vld_o;
    lsu_pkg::exu_req_t  exu_req_i;
    lsu_pkg::nice_req_t nice_req_i;
    lsu_pkg::mem_cmd_t  cmd_o;
    lsu_pkg::data_t     rsp_rdata_i;
    lsu_pkg::reg_idx_t  wb_rdidx_o;
    lsu_pkg::reg_idx_t  nice_ret_rdidx_o;
    lsu_pkg::data_t     wb_wdata_o;
    lsu_pkg::data_t     nice_ret_wdata_o;

    op_t               ops[$];
    lsu_pkg::mem_cmd_t exp_cmd[$];
    int                exp_cmd_row[$];
    logic [31:0]       exp_res_data[$];
    logic [4:0]        exp_res_idx[$];
    bit                exp_res_ret[$];
    int                exp_res_row[$];
    logic [31:0]       rsp_data_q[$];
    logic [31:0]       mem [64];
    logic [31:0]       ref_mem [64];
    int                outstanding;
    bit                table_built;

    lsu_top #(
        .TAG_DEPTH (TAG_DEPTH)
    ) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [3:0] lane_mask(logic [1:0] size, logic [1:0] off);
        case (size)
            2'd0:    return 4'b0001 << off;
            2'd1:    return 4'b0011 << off;
            default: return 4'b1111;
        endcase
    endfunction

    function automatic logic [31:0] byte_keep(logic [3:0] mask);
        return {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
    endfunction

    function automatic logic [31:0] lane_data(logic [1:0] size, logic [31:0] d);
        case (size)
            2'd0:    return {4{d[7:0]}};
            2'd1:    return {2{d[15:0]}};
            default: return d;
        endcase
    endfunction

    function automatic logic [31:0] extract(logic [31:0] w, logic [1:0] size,
                                            logic [1:0] off, bit uns);
        logic [31:0] sh;
        sh = w >> (8 * off);
        case (size)
            2'd0:    return uns ? {24'b0, sh[7:0]} : {{24{sh[7]}}, sh[7:0]};
            2'd1:    return uns ? {16'b0, sh[15:0]} : {{16{sh[15]}}, sh[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic check_eq(input string name, input string what,
                            input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("FAIL %s %s expected %h actual %h", name, what, exp, act);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic add_op(input string name, input int src, input bit read,
                          input logic [31:0] base, input logic [31:0] imm,
                          input logic [31:0] data, input logic [1:0] size,
                          input bit uns, input logic [4:0] rdidx, input bit ret);
        op_t r;
        r = '{name, src, read, base, imm, data, size, uns, rdidx, ret};
        ops.push_back(r);
    endtask

    // reference model, updated in request order
    task automatic queue_expect(input int k, input logic [31:0] addr, input bit read,
                                input logic [31:0] d, input logic [1:0] size, input bit uns,
                                input logic [4:0] rdidx, input bit ret);
        lsu_pkg::mem_cmd_t c;
        c.read  = read;
        c.addr  = {addr[31:2], 2'b00};
        c.wmask = lane_mask(size, addr[1:0]);
        c.wdata = lane_data(size, d) & byte_keep(c.wmask);
        exp_cmd.push_back(c);
        exp_cmd_row.push_back(k);
        if (read) begin
            exp_res_data.push_back(extract(ref_mem[addr[7:2]], size, addr[1:0], uns));
            exp_res_idx.push_back(rdidx);
            exp_res_ret.push_back(ret);
            exp_res_row.push_back(k);
        end else begin
            ref_mem[addr[7:2]] = (ref_mem[addr[7:2]] & ~byte_keep(c.wmask)) | c.wdata;
        end
    endtask

    task automatic apply_op(input int k);
        op_t         o;
        logic [31:0] addr;
        bit          n_hs;
        bit          e_hs;
        o = ops[k];
        addr = o.base + o.imm;
        // coprocessor request goes first when both sources are valid
        if (o.src != 0) begin
            nice_req_i.read   = o.read;
            nice_req_i.addr   = addr;
            nice_req_i.wmask  = lane_mask(o.size, addr[1:0]);
            nice_req_i.wdata  = lane_data(o.size, o.data) & byte_keep(nice_req_i.wmask);
            nice_req_i.size   = o.size;
            nice_req_i.unsign = o.unsign;
            nice_req_i.rdidx  = o.rdidx;
            nice_req_i.ret    = o.ret;
            nice_vld_i = 1'b1;
            queue_expect(k, addr, o.read, o.data, o.size, o.unsign, o.rdidx, o.ret);
        end
        if (o.src != 1) begin
            exu_req_i.rs1    = o.base;
            exu_req_i.imm    = o.imm;
            exu_req_i.rs2    = o.data;
            exu_req_i.rdidx  = (o.src == 2) ? o.rdidx + 5'd1 : o.rdidx;
            exu_req_i.load   = o.read;
            exu_req_i.size   = o.size;
            exu_req_i.unsign = o.unsign;
            exu_vld_i = 1'b1;
            queue_expect(k, addr, o.read, o.data, o.size, o.unsign, exu_req_i.rdidx, 1'b0);
        end
        forever begin
            @(negedge clk);
            n_hs = nice_vld_i && nice_rdy_o;
            e_hs = exu_vld_i && exu_rdy_o;
            @(posedge clk);
            #1;
            if (n_hs) nice_vld_i = 1'b0;
            if (e_hs) exu_vld_i = 1'b0;
            if (!nice_vld_i && !exu_vld_i) break;
        end
    endtask

    task automatic check_result(input bit ret, input logic [4:0] idx, input logic [31:0] d);
        string name;
        assert (exp_res_data.size() > 0) else begin
            $display("a load result came back with no load outstanding");
            $display("TEST FAILED");
            $fatal(1);
        end
        name = ops[exp_res_row[0]].name;
        check_eq(name, "return port", exp_res_ret[0], ret);
        check_eq(name, "rdidx", exp_res_idx[0], idx);
        check_eq(name, "load data", exp_res_data[0], d);
        void'(exp_res_data.pop_front());
        void'(exp_res_idx.pop_front());
        void'(exp_res_ret.pop_front());
        void'(exp_res_row.pop_front());
    endtask

    task automatic check_valids_low(input string name);
        check_eq(name, "cmd_vld_o", 0, cmd_vld_o);
        check_eq(name, "wb_vld_o", 0, wb_vld_o);
        check_eq(name, "nice_ret_vld_o", 0, nice_ret_vld_o);
    endtask

    // monitor samples at the falling edge, where every output is settled
    always @(negedge clk) begin
        if (rst_n_i) begin
            if (cmd_vld_o && cmd_rdy_i) begin
                assert (exp_cmd.size() > 0) else begin
                    $display("a memory command was issued that no request asked for");
                    $display("TEST FAILED");
                    $fatal(1);
                end
                check_eq(ops[exp_cmd_row[0]].name, "cmd read", exp_cmd[0].read, cmd_o.read);
                check_eq(ops[exp_cmd_row[0]].name, "cmd addr", exp_cmd[0].addr, cmd_o.addr);
                check_eq(ops[exp_cmd_row[0]].name, "cmd wmask", exp_cmd[0].wmask, cmd_o.wmask);
                check_eq(ops[exp_cmd_row[0]].name, "cmd wdata", exp_cmd[0].wdata, cmd_o.wdata);
                void'(exp_cmd.pop_front());
                void'(exp_cmd_row.pop_front());
                if (cmd_o.read) begin
                    rsp_data_q.push_back(mem[cmd_o.addr[7:2]]);
                end else begin
                    mem[cmd_o.addr[7:2]] = (mem[cmd_o.addr[7:2]] & ~byte_keep(cmd_o.wmask))
                                           | (cmd_o.wdata & byte_keep(cmd_o.wmask));
                    rsp_data_q.push_back(32'h0);
                end
            end
            outstanding = outstanding + int'(cmd_vld_o && cmd_rdy_i);
            assert (outstanding <= TAG_DEPTH) else begin
                $display("more commands outstanding than the tag queue can hold");
                $display("TEST FAILED");
                $fatal(1);
            end
            outstanding = outstanding - int'(rsp_vld_i && rsp_rdy_o);
            if (wb_vld_o && wb_rdy_i) check_result(1'b0, wb_rdidx_o, wb_wdata_o);
            if (nice_ret_vld_o && nice_ret_rdy_i) begin
                check_result(1'b1, nice_ret_rdidx_o, nice_ret_wdata_o);
            end
        end
    end

    // memory responder, in order, 0 to 3 idle cycles before each answer
    initial begin
        rsp_vld_i   = 1'b0;
        rsp_rdata_i = '0;
        forever begin
            @(posedge clk);
            #1;
            if (rsp_data_q.size() > 0) begin
                repeat ($urandom % 4) begin
                    @(posedge clk);
                    #1;
                end
                rsp_vld_i   = 1'b1;
                rsp_rdata_i = rsp_data_q[0];
                do @(negedge clk); while (!rsp_rdy_o);
                @(posedge clk);
                #1;
                rsp_vld_i   = 1'b0;
                rsp_rdata_i = $urandom;
                void'(rsp_data_q.pop_front());
            end
        end
    end

    initial begin
        cmd_rdy_i      = 1'b0;
        wb_rdy_i       = 1'b0;
        nice_ret_rdy_i = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            cmd_rdy_i      = ($urandom % 4) != 0;
            wb_rdy_i       = ($urandom % 3) != 0;
            nice_ret_rdy_i = ($urandom % 3) != 0;
        end
    end

    initial begin
        wait (table_built);
        repeat (ops.size() * 50 + 8) @(posedge clk);
        $display("timeout: the operations did not complete in time");
        $display("TEST FAILED");
        $fatal(1);
    end

    initial begin
        void'($urandom(32'hea2e_323e));
        rst_n_i     = 1'b0;
        exu_vld_i   = 1'b0;
        nice_vld_i  = 1'b0;
        exu_req_i   = '0;
        nice_req_i  = '0;
        outstanding = 0;
        for (int i = 0; i < 64; i++) begin
            mem[i]     = (32'h9e37_79b9 * (i + 1)) ^ (i << 26);
            ref_mem[i] = mem[i];
        end
        add_op("sb_off0", 0, 0, 32'h40, 32'h0, 32'h1234_56a5, 2'd0, 0, 5'd0, 0);
        add_op("sb_off1", 0, 0, 32'h40, 32'h1, 32'h1234_5617, 2'd0, 0, 5'd0, 0);
        add_op("sb_off2", 0, 0, 32'h40, 32'h2, 32'h1234_56c3, 2'd0, 0, 5'd0, 0);
        add_op("sb_off3", 0, 0, 32'h3c, 32'h7, 32'h1234_5654, 2'd0, 0, 5'd0, 0);
        add_op("sh_off0", 0, 0, 32'h44, 32'h0, 32'hbeef_8c71, 2'd1, 0, 5'd0, 0);
        add_op("sh_off2", 0, 0, 32'h44, 32'h2, 32'h0bad_1e2f, 2'd1, 0, 5'd0, 0);
        add_op("sw_off0", 0, 0, 32'h50, 32'hffff_fff8, 32'hcafe_f00d, 2'd2, 0, 5'd0, 0);
        add_op("lb_off0", 0, 1, 32'h40, 32'h0, 32'h0, 2'd0, 0, 5'd1, 0);
        add_op("lb_off1", 0, 1, 32'h40, 32'h1, 32'h0, 2'd0, 0, 5'd2, 0);
        add_op("lb_off2", 0, 1, 32'h40, 32'h2, 32'h0, 2'd0, 0, 5'd3, 0);
        add_op("lb_off3", 0, 1, 32'h40, 32'h3, 32'h0, 2'd0, 0, 5'd4, 0);
        add_op("lbu_off0", 0, 1, 32'h40, 32'h0, 32'h0, 2'd0, 1, 5'd5, 0);
        add_op("lbu_off3", 0, 1, 32'h80, 32'h7, 32'h0, 2'd0, 1, 5'd6, 0);
        add_op("lh_off0", 0, 1, 32'h44, 32'h0, 32'h0, 2'd1, 0, 5'd7, 0);
        add_op("lh_off2", 0, 1, 32'h44, 32'h2, 32'h0, 2'd1, 0, 5'd8, 0);
        add_op("lhu_off0", 0, 1, 32'h44, 32'h0, 32'h0, 2'd1, 1, 5'd9, 0);
        add_op("lhu_off2", 0, 1, 32'h88, 32'h2, 32'h0, 2'd1, 1, 5'd10, 0);
        add_op("lw_store", 0, 1, 32'h48, 32'h0, 32'h0, 2'd2, 0, 5'd11, 0);
        add_op("lw_fill", 0, 1, 32'h90, 32'hffff_fff0, 32'h0, 2'd2, 0, 5'd12, 0);
        add_op("nice_sw", 1, 0, 32'h54, 32'h0, 32'h8765_4321, 2'd2, 0, 5'd0, 0);
        add_op("nice_lh_ret", 1, 1, 32'h56, 32'h0, 32'h0, 2'd1, 0, 5'd13, 1);
        add_op("nice_lbu_wb", 1, 1, 32'h55, 32'h0, 32'h0, 2'd0, 1, 5'd14, 0);
        add_op("both_lw", 2, 1, 32'h54, 32'h0, 32'h0, 2'd2, 0, 5'd15, 1);
        add_op("both_sb", 2, 0, 32'h58, 32'h1, 32'h0000_0099, 2'd0, 0, 5'd0, 0);
        add_op("lw_after_both", 0, 1, 32'h58, 32'h0, 32'h0, 2'd2, 0, 5'd17, 0);
        table_built = 1'b1;

        @(posedge clk);
        repeat (7) begin
            @(negedge clk);
            check_valids_low("reset");
            @(posedge clk);
        end
        #1;
        rst_n_i = 1'b1;
        @(negedge clk);
        check_valids_low("after_reset");

        @(posedge clk);
        #1;
        for (int k = 0; k < ops.size(); k++) begin
            apply_op(k);
            repeat ($urandom % 2) begin
                @(posedge clk);
                #1;
            end
        end
        while (exp_cmd.size() > 0 || rsp_data_q.size() > 0 || exp_res_data.size() > 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        for (int i = 0; i < 64; i++) begin
            check_eq("memory", $sformatf("word %0d", i), ref_mem[i], mem[i]);
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- tests/lsu_props.sv
`timescale 1ns/1ps

module lsu_props (
    input logic              clk,
    input logic              rst_n_i,
    input logic              cmd_vld_o,
    input logic              cmd_rdy_i,
    input lsu_pkg::mem_cmd_t cmd_o,
    input logic              wb_vld_o,
    input logic              wb_rdy_i,
    input lsu_pkg::reg_idx_t wb_rdidx_o,
    input lsu_pkg::data_t    wb_wdata_o,
    input logic              nice_ret_vld_o,
    input logic              nice_ret_rdy_i,
    input lsu_pkg::reg_idx_t nice_ret_rdidx_o,
    input lsu_pkg::data_t    nice_ret_wdata_o
);

    // a stalled command keeps its valid and its payload
    cmd_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        cmd_vld_o && !cmd_rdy_i |=> cmd_vld_o && $stable(cmd_o))
        else $error("memory command changed while stalled");

    // a held result stays with its consumer until taken
    wb_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_vld_o && !wb_rdy_i |=> wb_vld_o && $stable(wb_rdidx_o) && $stable(wb_wdata_o))
        else $error("writeback result changed while stalled");

    nice_ret_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        nice_ret_vld_o && !nice_ret_rdy_i |=> nice_ret_vld_o
            && $stable(nice_ret_rdidx_o) && $stable(nice_ret_wdata_o))
        else $error("coprocessor return result changed while stalled");

    reset_quiet: assert property (@(posedge clk)
        $rose(rst_n_i) |-> !cmd_vld_o && !wb_vld_o && !nice_ret_vld_o)
        else $error("valid output high right after reset");

endmodule

bind lsu_top lsu_props i_props (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .cmd_vld_o        (cmd_vld_o),
    .cmd_rdy_i        (cmd_rdy_i),
    .cmd_o            (cmd_o),
    .wb_vld_o         (wb_vld_o),
    .wb_rdy_i         (wb_rdy_i),
    .wb_rdidx_o       (wb_rdidx_o),
    .wb_wdata_o       (wb_wdata_o),
    .nice_ret_vld_o   (nice_ret_vld_o),
    .nice_ret_rdy_i   (nice_ret_rdy_i),
    .nice_ret_rdidx_o (nice_ret_rdidx_o),
    .nice_ret_wdata_o (nice_ret_wdata_o)
);

//--- verilog/lsu_top.sv
`timescale 1ns/1ps

module lsu_top #(
    parameter int TAG_DEPTH = 2
) (
    input  logic                clk,
    input  logic                rst_n_i,

    input  logic                exu_vld_i,
    input  lsu_pkg::exu_req_t   exu_req_i,
    output logic                exu_rdy_o,

    input  logic                nice_vld_i,
    input  lsu_pkg::nice_req_t  nice_req_i,
    output logic                nice_rdy_o,

    output logic                cmd_vld_o,
    output lsu_pkg::mem_cmd_t   cmd_o,
    input  logic                cmd_rdy_i,

    input  logic                rsp_vld_i,
    input  lsu_pkg::data_t      rsp_rdata_i,
    output logic                rsp_rdy_o,

    output logic                wb_vld_o,
    output lsu_pkg::reg_idx_t   wb_rdidx_o,
    output lsu_pkg::data_t      wb_wdata_o,
    input  logic                wb_rdy_i,

    output logic                nice_ret_vld_o,
    output lsu_pkg::reg_idx_t   nice_ret_rdidx_o,
    output lsu_pkg::data_t      nice_ret_wdata_o,
    input  logic                nice_ret_rdy_i
);

    lsu_pkg::lsu_req_t exu_req;
    lsu_pkg::lsu_tag_t cmd_tag;
    lsu_pkg::lsu_tag_t head_tag;
    lsu_pkg::data_t    load_data;
    lsu_pkg::data_t    ret_wdata;
    lsu_pkg::reg_idx_t ret_rdidx;
    logic              tag_push;
    logic              tag_pop;
    logic              tag_full;
    logic              tag_empty;
    logic              rsp_vld;

    // one tag per accepted command, one pop per response
    assign tag_push = cmd_vld_o & cmd_rdy_i;
    assign rsp_vld  = rsp_vld_i & ~tag_empty;
    assign tag_pop  = rsp_vld & rsp_rdy_o;

    lsu_store_align i_store_align (
        .exu_req_i (exu_req_i),
        .req_o     (exu_req)
    );

    lsu_issue i_issue (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .exu_vld_i  (exu_vld_i),
        .exu_req_i  (exu_req),
        .exu_rdy_o  (exu_rdy_o),
        .nice_vld_i (nice_vld_i),
        .nice_req_i (nice_req_i),
        .nice_rdy_o (nice_rdy_o),
        .tag_full_i (tag_full),
        .cmd_vld_o  (cmd_vld_o),
        .cmd_rdy_i  (cmd_rdy_i),
        .cmd_o      (cmd_o),
        .tag_o      (cmd_tag)
    );

    lsu_tag_fifo #(
        .TAG_DEPTH (TAG_DEPTH)
    ) i_tag_fifo (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .push_i  (tag_push),
        .tag_i   (cmd_tag),
        .full_o  (tag_full),
        .pop_i   (tag_pop),
        .head_o  (head_tag),
        .empty_o (tag_empty)
    );

    lsu_load_extract i_load_extract (
        .tag_i   (head_tag),
        .rdata_i (rsp_rdata_i),
        .data_o  (load_data)
    );

    lsu_ret_buf i_ret_buf (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .rsp_vld_i      (rsp_vld),
        .tag_i          (head_tag),
        .data_i         (load_data),
        .rsp_rdy_o      (rsp_rdy_o),
        .wb_vld_o       (wb_vld_o),
        .wb_rdy_i       (wb_rdy_i),
        .nice_ret_vld_o (nice_ret_vld_o),
        .nice_ret_rdy_i (nice_ret_rdy_i),
        .rdidx_o        (ret_rdidx),
        .wdata_o        (ret_wdata)
    );

    // both consumers see the same buffered result
    assign wb_rdidx_o       = ret_rdidx;
    assign wb_wdata_o       = ret_wdata;
    assign nice_ret_rdidx_o = ret_rdidx;
    assign nice_ret_wdata_o = ret_wdata;

endmodule

//--- verilog/lsu_ret_buf.sv
`timescale 1ns/1ps

module lsu_ret_buf (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              rsp_vld_i,
    input  lsu_pkg::lsu_tag_t tag_i,
    input  lsu_pkg::data_t    data_i,
    output logic              rsp_rdy_o,
    output logic              wb_vld_o,
    input  logic              wb_rdy_i,
    output logic              nice_ret_vld_o,
    input  logic              nice_ret_rdy_i,
    output lsu_pkg::reg_idx_t rdidx_o,
    output lsu_pkg::data_t    wdata_o
);

    logic buf_vld;
    logic buf_ret;
    logic out_rdy;
    logic buf_free;
    logic load_in;

    // ready from whichever consumer owns the held result
    assign out_rdy  = buf_ret ? nice_ret_rdy_i : wb_rdy_i;
    assign buf_free = ~buf_vld | out_rdy;
    assign load_in  = rsp_vld_i & tag_i.read;

    // store responses are always sunk
    assign rsp_rdy_o = tag_i.read ? buf_free : 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            buf_vld <= 1'b0;
        end else if (buf_free) begin
            buf_vld <= load_in;
        end
    end

    always_ff @(posedge clk) begin
        if (buf_free && load_in) begin
            buf_ret <= tag_i.ret;
            rdidx_o <= tag_i.rdidx;
            wdata_o <= data_i;
        end
    end

    assign wb_vld_o       = buf_vld & ~buf_ret;
    assign nice_ret_vld_o = buf_vld & buf_ret;

endmodule

//--- verilog/lsu_load_extract.sv
`timescale 1ns/1ps

module lsu_load_extract (
    input  lsu_pkg::lsu_tag_t tag_i,
    input  lsu_pkg::data_t    rdata_i,
    output lsu_pkg::data_t    data_o
);

    logic [7:0]  byte_val;
    logic [15:0] half_val;

    // byte at any offset, half at offset 0 or 2
    assign byte_val = rdata_i[{tag_i.offset, 3'b000} +: 8];
    assign half_val = tag_i.offset[1] ? rdata_i[31:16] : rdata_i[15:0];

    always_comb begin
        case (tag_i.size)
            lsu_pkg::SIZE_BYTE: begin
                if (tag_i.unsign) begin
                    data_o = {{(lsu_pkg::DATA_W-8){1'b0}}, byte_val};
                end else begin
                    data_o = {{(lsu_pkg::DATA_W-8){byte_val[7]}}, byte_val};
                end
            end
            lsu_pkg::SIZE_HALF: begin
                if (tag_i.unsign) begin
                    data_o = {{(lsu_pkg::DATA_W-16){1'b0}}, half_val};
                end else begin
                    data_o = {{(lsu_pkg::DATA_W-16){half_val[15]}}, half_val};
                end
            end
            // full word passes through
            default: begin
                data_o = rdata_i;
            end
        endcase
    end

endmodule

//--- verilog/lsu_tag_fifo.sv
`timescale 1ns/1ps

module lsu_tag_fifo #(
    parameter int TAG_DEPTH = 2
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              push_i,
    input  lsu_pkg::lsu_tag_t tag_i,
    output logic              full_o,
    input  logic              pop_i,
    output lsu_pkg::lsu_tag_t head_o,
    output logic              empty_o
);

    localparam int PTR_W = (TAG_DEPTH > 1) ? $clog2(TAG_DEPTH) : 1;
    localparam int CNT_W = $clog2(TAG_DEPTH + 1);

    lsu_pkg::lsu_tag_t mem [TAG_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(TAG_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= (rd_ptr == PTR_W'(TAG_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= tag_i;
        end
    end

    assign head_o  = mem[rd_ptr];
    assign full_o  = (count == CNT_W'(TAG_DEPTH));
    assign empty_o = (count == '0);

endmodule

//--- verilog/lsu_issue.sv
`timescale 1ns/1ps

module lsu_issue (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               exu_vld_i,
    input  lsu_pkg::lsu_req_t  exu_req_i,
    output logic               exu_rdy_o,
    input  logic               nice_vld_i,
    input  lsu_pkg::nice_req_t nice_req_i,
    output logic               nice_rdy_o,
    input  logic               tag_full_i,
    output logic               cmd_vld_o,
    input  logic               cmd_rdy_i,
    output lsu_pkg::mem_cmd_t  cmd_o,
    output lsu_pkg::lsu_tag_t  tag_o
);

    lsu_pkg::lsu_req_t nice_req;
    lsu_pkg::lsu_req_t arb_req;
    lsu_pkg::lsu_req_t skid_req;
    lsu_pkg::lsu_req_t out_req;
    lsu_pkg::mem_cmd_t cmd_q;
    lsu_pkg::lsu_tag_t tag_q;
    logic              arb_vld;
    logic              arb_rdy;
    logic              skid_vld;
    logic              out_vld;
    logic              cmd_vld_q;
    logic              reg_rdy;

    always_comb begin
        nice_req.read   = nice_req_i.read;
        nice_req.addr   = nice_req_i.addr;
        nice_req.wdata  = nice_req_i.wdata;
        nice_req.wmask  = nice_req_i.wmask;
        nice_req.size   = nice_req_i.size;
        nice_req.unsign = nice_req_i.unsign;
        nice_req.rdidx  = nice_req_i.rdidx;
        nice_req.ret    = nice_req_i.ret;
    end

    // coprocessor wins whenever it is valid
    assign arb_req    = nice_vld_i ? nice_req : exu_req_i;
    assign arb_vld    = nice_vld_i | exu_vld_i;
    assign nice_rdy_o = nice_vld_i & arb_rdy;
    assign exu_rdy_o  = ~nice_vld_i & arb_rdy;

    // skid buffer, source ready comes from a flop only
    assign arb_rdy = ~skid_vld;
    assign out_vld = skid_vld | arb_vld;
    assign out_req = skid_vld ? skid_req : arb_req;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            skid_vld <= 1'b0;
        end else if (skid_vld) begin
            if (reg_rdy) begin
                skid_vld <= 1'b0;
            end
        end else if (arb_vld && !reg_rdy) begin
            skid_vld <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!skid_vld && arb_vld && !reg_rdy) begin
            skid_req <= arb_req;
        end
    end

    // command register, refills in the cycle its command is taken
    assign reg_rdy = ~cmd_vld_q | (cmd_vld_o & cmd_rdy_i);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            cmd_vld_q <= 1'b0;
        end else if (reg_rdy) begin
            cmd_vld_q <= out_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (reg_rdy && out_vld) begin
            cmd_q.read   <= out_req.read;
            cmd_q.addr   <= {out_req.addr[lsu_pkg::ADDR_W-1:2], 2'b00};
            cmd_q.wdata  <= out_req.wdata;
            cmd_q.wmask  <= out_req.wmask;
            // byte offset travels with the tag for load extraction
            tag_q.read   <= out_req.read;
            tag_q.rdidx  <= out_req.rdidx;
            tag_q.unsign <= out_req.unsign;
            tag_q.size   <= out_req.size;
            tag_q.offset <= out_req.addr[1:0];
            tag_q.ret    <= out_req.ret;
        end
    end

    // no issue while every tag slot is taken
    assign cmd_vld_o = cmd_vld_q & ~tag_full_i;
    assign cmd_o     = cmd_q;
    assign tag_o     = tag_q;

endmodule

//--- verilog/lsu_store_align.sv
`timescale 1ns/1ps

module lsu_store_align (
    input  lsu_pkg::exu_req_t exu_req_i,
    output lsu_pkg::lsu_req_t req_o
);

    lsu_pkg::addr_t   addr;
    lsu_pkg::offset_t offset;
    lsu_pkg::wmask_t  wmask;
    lsu_pkg::data_t   lane_data;
    lsu_pkg::data_t   lane_keep;

    assign addr   = exu_req_i.rs1 + exu_req_i.imm;
    assign offset = addr[1:0];

    // byte enables and replicated store data per size
    always_comb begin
        case (exu_req_i.size)
            lsu_pkg::SIZE_BYTE: begin
                wmask     = 4'b0001 << offset;
                lane_data = {4{exu_req_i.rs2[7:0]}};
            end
            lsu_pkg::SIZE_HALF: begin
                // halfword sits at offset 0 or 2
                wmask     = 4'b0011 << {offset[1], 1'b0};
                lane_data = {2{exu_req_i.rs2[15:0]}};
            end
            lsu_pkg::SIZE_WORD: begin
                wmask     = 4'b1111;
                lane_data = exu_req_i.rs2;
            end
            default: begin
                wmask     = 4'b0000;
                lane_data = '0;
            end
        endcase
    end

    // lanes outside the mask are driven as zero
    always_comb begin
        for (int i = 0; i < lsu_pkg::STRB_W; i++) begin
            lane_keep[8*i +: 8] = {8{wmask[i]}};
        end
    end

    always_comb begin
        req_o.read   = exu_req_i.load;
        req_o.addr   = addr;
        req_o.wdata  = lane_data & lane_keep;
        req_o.wmask  = wmask;
        req_o.size   = exu_req_i.size;
        req_o.unsign = exu_req_i.unsign;
        req_o.rdidx  = exu_req_i.rdidx;
        // execute-unit results always go to writeback
        req_o.ret    = 1'b0;
    end

endmodule

//--- common/lsu_pkg.sv
package lsu_pkg;

    // fixed 32-bit data path
    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;
    localparam int STRB_W = DATA_W / 8;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [STRB_W-1:0] wmask_t;
    typedef logic [4:0]        reg_idx_t;
    typedef logic [1:0]        size_t;
    typedef logic [1:0]        offset_t;

    // access size codes, as in funct3[1:0] of loads and stores
    localparam size_t SIZE_BYTE = 2'd0;
    localparam size_t SIZE_HALF = 2'd1;
    localparam size_t SIZE_WORD = 2'd2;

    // request from the execute unit, address not yet formed
    typedef struct packed {
        data_t    rs1;
        data_t    imm;
        data_t    rs2;
        reg_idx_t rdidx;
        logic     load;
        size_t    size;
        logic     unsign;
    } exu_req_t;

    // coprocessor request, already lane aligned by the sender
    typedef struct packed {
        logic     read;
        addr_t    addr;
        data_t    wdata;
        wmask_t   wmask;
        size_t    size;
        logic     unsign;
        reg_idx_t rdidx;
        logic     ret;
    } nice_req_t;

    // common request format ahead of the issue stage
    typedef struct packed {
        logic     read;
        addr_t    addr;
        data_t    wdata;
        wmask_t   wmask;
        size_t    size;
        logic     unsign;
        reg_idx_t rdidx;
        logic     ret;
    } lsu_req_t;

    // kept per outstanding command until its response
    typedef struct packed {
        logic     read;
        reg_idx_t rdidx;
        logic     unsign;
        size_t    size;
        offset_t  offset;
        logic     ret;
    } lsu_tag_t;

    typedef struct packed {
        logic   read;
        addr_t  addr;
        data_t  wdata;
        wmask_t wmask;
    } mem_cmd_t;

endpackage
